/* src/core_control.sv */
`timescale 1ns/1ps

module core_control (
    input  logic              clk,
    input  logic              native_rstn,
    input  logic              usr_rst,
    input  rv_pkg::decoded_t  dec,
    input  logic              accepted,
    input  logic              done,
    input  rv_pkg::word_t     result,
    input  logic              branch_taken,
    fetch_if.ctrl             f,
    output rv_pkg::word_t     fetch_inst,
    output rv_pkg::word_t     fetch_pc,
    output logic              start,
    output rv_pkg::decoded_t  dec_q,
    output logic              we,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     rd_data,
    output logic              retire_valid,
    output rv_pkg::word_t     retire_pc,
    output logic              retire_we,
    output rv_pkg::reg_addr_t retire_rd,
    output rv_pkg::word_t     retire_data,
    output logic              halted
);
    import rv_pkg::*;

    state_e state;
    word_t  pc;
    word_t  next_pc_q;
    word_t  wdata_q;
    logic   wr_en_q;

    always_ff @(posedge clk) begin
        if (!native_rstn || usr_rst) begin
            state      <= st_idle;
            pc         <= '0;
            next_pc_q  <= '0;
            wdata_q    <= '0;
            wr_en_q    <= 1'b0;
            fetch_inst <= '0;
            fetch_pc   <= '0;
            dec_q      <= '0;
            f.order    <= 1'b0;
            start      <= 1'b0;
        end else begin
            case (state)
                st_idle: state <= st_fetch;
                st_fetch: begin
                    f.order <= 1'b1;
                    state   <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (f.accepted) begin
                        f.order <= 1'b0;
                    end
                    if (f.done) begin
                        fetch_inst <= f.inst;
                        fetch_pc   <= pc;
                        state      <= st_decode;
                    end
                end
                st_decode: begin
                    dec_q <= dec;
                    state <= st_execute;
                end
                st_execute: begin
                    next_pc_q <= pc + pc_step;
                    case (dec_q.kind)
                        kind_alu: begin
                            start <= 1'b1;
                            state <= st_execute_wait;
                        end
                        kind_branch: begin
                            if (branch_taken) begin
                                next_pc_q <= dec_q.opnd_c;
                            end
                            wr_en_q <= 1'b0;
                            state   <= st_write;
                        end
                        kind_link: begin
                            next_pc_q <= pc_align(dec_q.opnd_c);
                            wdata_q   <= pc + pc_step;
                            wr_en_q   <= 1'b1;
                            state     <= st_write;
                        end
                        kind_lui: begin
                            wdata_q <= dec_q.opnd_c;
                            wr_en_q <= 1'b1;
                            state   <= st_write;
                        end
                        default: state <= st_halt;
                    endcase
                end
                st_execute_wait: begin
                    if (accepted) begin
                        start <= 1'b0;
                    end
                    if (done) begin
                        wdata_q <= result;
                        wr_en_q <= 1'b1;
                        state   <= st_write;
                    end
                end
                st_write: begin
                    pc    <= pc_align(next_pc_q);
                    state <= st_fetch;
                end
                default: state <= st_halt;
            endcase
        end
    end

    assign f.pc = pc;

    // write-back commits at the end of the write state
    assign we      = (state == st_write) & wr_en_q;
    assign rd      = dec_q.rd;
    assign rd_data = wdata_q;

    assign retire_valid = (state == st_write);
    assign retire_pc    = pc;
    assign retire_we    = we;
    assign retire_rd    = dec_q.rd;
    assign retire_data  = wdata_q;
    assign halted       = (state == st_halt);

endmodule

/* src/core_ifs.sv */
`timescale 1ns/1ps

// instruction fetch order between sequencer and fetch unit
interface fetch_if;
    import rv_pkg::*;

    logic  order;
    logic  accepted;
    logic  done;
    word_t pc;
    word_t inst;

    modport ctrl (output order, output pc, input accepted, input done, input inst);
    modport unit (input order, input pc, output accepted, output done, output inst);
endinterface

// combinational register read
interface reg_read_if;
    import rv_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;

    modport reader (output rs1, output rs2, input rs1_data, input rs2_data);
    modport port (input rs1, input rs2, output rs1_data, output rs2_data);
endinterface

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic                           clk,
    input  logic                           native_rstn,
    input  logic                           usr_rst,
    output logic [rv_pkg::imem_addr_w-1:0] imem_addr,
    input  rv_pkg::word_t                  imem_data,
    output logic                           retire_valid,
    output rv_pkg::word_t                  retire_pc,
    output logic                           retire_we,
    output rv_pkg::reg_addr_t              retire_rd,
    output rv_pkg::word_t                  retire_data,
    output logic                           halted
);
    import rv_pkg::*;

    fetch_if    f_bus ();
    reg_read_if rr_bus ();

    decoded_t  dec;
    decoded_t  dec_q;
    word_t     fetch_inst;
    word_t     fetch_pc;
    logic      alu_start;
    logic      alu_accepted;
    logic      alu_done;
    word_t     alu_result;
    logic      branch_taken;
    logic      we;
    reg_addr_t rd;
    word_t     rd_data;

    core_control core_control_inst (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .usr_rst      (usr_rst),
        .dec          (dec),
        .accepted     (alu_accepted),
        .done         (alu_done),
        .result       (alu_result),
        .branch_taken (branch_taken),
        .f            (f_bus.ctrl),
        .fetch_inst   (fetch_inst),
        .fetch_pc     (fetch_pc),
        .start        (alu_start),
        .dec_q        (dec_q),
        .we           (we),
        .rd           (rd),
        .rd_data      (rd_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    inst_fetch inst_fetch_inst (
        .clk         (clk),
        .native_rstn (native_rstn),
        .usr_rst     (usr_rst),
        .f           (f_bus.unit),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data)
    );

    inst_decode inst_decode_inst (
        .inst (fetch_inst),
        .pc   (fetch_pc),
        .rr   (rr_bus.reader),
        .dec  (dec)
    );

    exec_unit exec_unit_inst (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .usr_rst      (usr_rst),
        .start        (alu_start),
        .dec          (dec_q),
        .accepted     (alu_accepted),
        .done         (alu_done),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    reg_file reg_file_inst (
        .clk         (clk),
        .native_rstn (native_rstn),
        .rr          (rr_bus.port),
        .we          (we),
        .rd          (rd),
        .rd_data     (rd_data)
    );

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic             clk,
    input  logic             native_rstn,
    input  logic             usr_rst,
    input  logic             start,
    input  rv_pkg::decoded_t dec,
    output logic             accepted,
    output logic             done,
    output rv_pkg::word_t    result,
    output logic             branch_taken
);
    import rv_pkg::*;

    logic       take;
    logic [4:0] shamt;
    logic [2:0] f3;
    logic       cond;
    word_t      alu_out;

    assign take  = start & ~accepted & ~done;
    assign shamt = dec.opnd_b[4:0];
    assign f3    = dec.alu_fn;

    always_comb begin
        case (dec.alu_fn)
            // sub only exists as a register op
            alu_add:  alu_out = (dec.alt && !dec.use_imm) ? dec.opnd_a - dec.opnd_b
                                                          : dec.opnd_a + dec.opnd_b;
            alu_sll:  alu_out = dec.opnd_a << shamt;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(dec.opnd_a) < $signed(dec.opnd_b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, dec.opnd_a < dec.opnd_b};
            alu_xor:  alu_out = dec.opnd_a ^ dec.opnd_b;
            alu_srl:  alu_out = dec.alt ? word_t'($signed(dec.opnd_a) >>> shamt)
                                        : dec.opnd_a >> shamt;
            alu_or:   alu_out = dec.opnd_a | dec.opnd_b;
            default:  alu_out = dec.opnd_a & dec.opnd_b;
        endcase
    end

    // branch compare on funct3
    always_comb begin
        case (f3)
            3'b000:  cond = dec.opnd_a == dec.opnd_b;
            3'b001:  cond = dec.opnd_a != dec.opnd_b;
            3'b100:  cond = $signed(dec.opnd_a) < $signed(dec.opnd_b);
            3'b101:  cond = $signed(dec.opnd_a) >= $signed(dec.opnd_b);
            3'b110:  cond = dec.opnd_a < dec.opnd_b;
            3'b111:  cond = dec.opnd_a >= dec.opnd_b;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = (dec.kind == kind_branch) & cond;

    always_ff @(posedge clk) begin
        if (!native_rstn || usr_rst) begin
            accepted <= 1'b0;
            done     <= 1'b0;
        end else begin
            accepted <= take;
            done     <= accepted;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            result <= alu_out;
        end
    end

endmodule

/* src/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  rv_pkg::word_t    inst,
    input  rv_pkg::word_t    pc,
    reg_read_if.reader       rr,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];

    assign rr.rs1 = inst[19:15];
    assign rr.rs2 = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec         = '0;
        dec.kind    = kind_illegal;
        dec.alu_fn  = alu_fn_e'(funct3);
        dec.opnd_a  = rr.rs1_data;
        dec.opnd_b  = rr.rs2_data;
        dec.rd      = rd;

        case (opcode)
            opc_op: begin
                dec.kind = kind_alu;
                dec.alt  = inst[30];
            end
            opc_op_imm: begin
                dec.kind    = kind_alu;
                // srai keeps bit 30, exec ignores it for add
                dec.alt     = inst[30];
                dec.use_imm = 1'b1;
                dec.opnd_b  = imm_i;
            end
            opc_lui: begin
                dec.kind   = kind_lui;
                dec.opnd_c = imm_u;
            end
            opc_jal: begin
                dec.kind   = kind_link;
                dec.opnd_c = pc + imm_j;
            end
            opc_jalr: begin
                dec.kind   = kind_link;
                dec.opnd_c = rr.rs1_data + imm_i;
            end
            opc_branch: begin
                dec.kind   = kind_branch;
                dec.opnd_c = pc + imm_b;
                dec.rd     = '0;
            end
            default: begin
                dec.kind = kind_illegal;
                dec.rd   = '0;
            end
        endcase
    end

endmodule

/* src/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch (
    input  logic                            clk,
    input  logic                            native_rstn,
    input  logic                            usr_rst,
    fetch_if.unit                           f,
    output logic [rv_pkg::imem_addr_w-1:0]  imem_addr,
    input  rv_pkg::word_t                   imem_data
);
    import rv_pkg::*;

    logic                   accepted_q;
    logic                   done_q;
    logic [imem_addr_w-1:0] addr_q;
    logic                   take;

    // new order only when no fetch is in progress
    assign take = f.order & ~accepted_q & ~done_q;

    always_ff @(posedge clk) begin
        if (!native_rstn || usr_rst) begin
            accepted_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            accepted_q <= take;
            done_q     <= accepted_q;
        end
    end

    // word address, byte offset dropped
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q <= f.pc[imem_addr_w+1:2];
        end
    end

    assign imem_addr  = addr_q;
    assign f.accepted = accepted_q;
    assign f.done     = done_q;

    // memory answers one cycle after the address, in step with done
    assign f.inst = imem_data;

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              native_rstn,
    reg_read_if.port          rr,
    input  logic              we,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::word_t     rd_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!native_rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rr.rs1_data = (rr.rs1 == '0) ? '0 : regs[rr.rs1];
    assign rr.rs2_data = (rr.rs2 == '0) ? '0 : regs[rr.rs2];

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

    localparam int xlen        = 32;
    localparam int reg_addr_w  = 5;
    localparam int imem_addr_w = 10;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    // funct3 encoding of the integer ops
    typedef enum logic [2:0] {
        alu_add  = 3'b000,
        alu_sll  = 3'b001,
        alu_slt  = 3'b010,
        alu_sltu = 3'b011,
        alu_xor  = 3'b100,
        alu_srl  = 3'b101,
        alu_or   = 3'b110,
        alu_and  = 3'b111
    } alu_fn_e;

    typedef enum logic [2:0] {
        kind_alu,
        kind_branch,
        kind_link,
        kind_lui,
        kind_illegal
    } exec_kind_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write,
        st_halt
    } state_e;

    // alu_fn also carries funct3 for branches
    typedef struct packed {
        exec_kind_e kind;
        alu_fn_e    alu_fn;
        logic       alt;
        logic       use_imm;
        word_t      opnd_a;
        word_t      opnd_b;
        word_t      opnd_c;
        reg_addr_t  rd;
    } decoded_t;

    localparam word_t pc_step = 32'd4;

    function automatic word_t pc_align(word_t pc);
        return {pc[xlen-1:2], 2'b00};
    endfunction

endpackage

/* verification/rv_encode.svh */
`ifndef rv_encode_svh
`define rv_encode_svh

localparam logic [6:0] op_reg    = 7'h33;
localparam logic [6:0] op_imm    = 7'h13;
localparam logic [6:0] op_lui    = 7'h37;
localparam logic [6:0] op_jal    = 7'h6f;
localparam logic [6:0] op_jalr   = 7'h67;
localparam logic [6:0] op_branch = 7'h63;

function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic word_t enc_u(logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, op_lui};
endfunction

function automatic word_t enc_b(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
endfunction

function automatic word_t enc_j(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
endfunction

// funct3 2 and 3 are not branches, map them onto bltu/bgeu
function automatic logic [2:0] branch_f3(logic [2:0] sel);
    if (sel == 3'd2 || sel == 3'd3) begin
        return sel + 3'd4;
    end
    return sel;
endfunction

// random code only touches x0..x7
function automatic reg_addr_t pick_reg();
    logic [31:0] r;
    r = next_rand();
    return {2'b00, r[2:0]};
endfunction

task automatic build_program();
    int          i;
    int          t;
    logic [31:0] r;
    logic [31:0] r2;
    logic [2:0]  f3;
    reg_addr_t   ra;
    reg_addr_t   rb;
    reg_addr_t   rc;
    reg_addr_t   rt;
    logic        is_target [0:prog_len-1];

    for (i = 0; i < prog_len; i++) begin
        is_target[i] = 1'b0;
    end
    // x1..x7 get full values first, so a restart sees the same stream
    i = 0;
    for (int k = 1; k < 8; k++) begin
        r = next_rand();
        mem[i]     = enc_u(r[31:12], reg_addr_t'(k));
        mem[i + 1] = enc_i(r[11:0], reg_addr_t'(k), 3'd0, reg_addr_t'(k), op_imm);
        i += 2;
    end
    while (i < prog_len - 1) begin
        r  = next_rand();
        r2 = next_rand();
        ra = pick_reg();
        rb = pick_reg();
        rc = pick_reg();
        f3 = r[6:4];
        // forward target two to five words ahead
        t  = i + 2 + int'(r[8:7]);
        if (t > prog_len - 1) begin
            t = prog_len - 1;
        end
        case (r[3:0])
            4'd0, 4'd1: mem[i] = enc_u(r2[31:12], rc);
            4'd2, 4'd3, 4'd4: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    mem[i] = enc_i({1'b0, r2[6] & f3[2], 5'b0, r2[4:0]}, ra, f3, rc, op_imm);
                end else begin
                    mem[i] = enc_i(r2[11:0], ra, f3, rc, op_imm);
                end
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                mem[i] = enc_r({1'b0, r2[0] & (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                               rb, ra, f3, rc);
            end
            4'd9, 4'd10, 4'd11: begin
                // equal operands now and then so beq/bge get taken
                if (r2[3]) begin
                    rb = ra;
                end
                mem[i] = enc_b(13'((t - i) * 4), rb, ra, branch_f3(r2[2:0]));
                is_target[t] = 1'b1;
            end
            4'd12: begin
                mem[i] = enc_j(21'((t - i) * 4), rc);
                is_target[t] = 1'b1;
            end
            4'd13: begin
                // base load plus jalr, nobody may land between the two
                if (i + 1 < prog_len - 1 && !is_target[i + 1]) begin
                    rt = {2'b00, r2[2:0] | 3'b001};
                    mem[i]     = enc_i(12'(4 * t - 8), 5'd0, 3'd0, rt, op_imm);
                    mem[i + 1] = enc_i(12'(8 + int'(r2[5:4])), rt, 3'd0, rc, op_jalr);
                    is_target[t] = 1'b1;
                    i++;
                end else begin
                    mem[i] = enc_i(r2[11:0], ra, 3'd0, rc, op_imm);
                end
            end
            4'd14: mem[i] = enc_r(7'h00, rb, ra, f3, 5'd0);
            default: mem[i] = enc_r(7'h00, ra, 5'd0, 3'b110, rc);
        endcase
        i++;
    end
    mem[prog_len - 1] = 32'h0000_0000;
endtask

`endif

/* verification/cpu_core_tb.sv */
`timescale 1ns/1ps

module cpu_core_tb;
    import rv_pkg::*;

    localparam int prog_len        = 150;
    localparam int cycles_per_inst = 10;
    // two full runs plus reset, restart and idle checks
    localparam int max_cycles      = 2 * prog_len * cycles_per_inst + 1000;
    localparam int imem_words      = 1 << imem_addr_w;

    logic                   clk;
    logic                   native_rstn;
    logic                   usr_rst;
    logic [imem_addr_w-1:0] imem_addr;
    word_t                  imem_data;
    logic                   retire_valid;
    word_t                  retire_pc;
    logic                   retire_we;
    reg_addr_t              retire_rd;
    word_t                  retire_data;
    logic                   halted;

    word_t                  mem [0:imem_words-1];
    word_t                  ref_regs [0:31];
    logic [31:0]            rng_state;
    logic [imem_addr_w-1:0] mem_addr_q;

    word_t     exp_pc [$];
    logic      exp_we [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];

    int   value_errors;
    int   other_errors;
    int   ret_idx;
    int   cycles;
    logic halt_seen;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    `include "rv_encode.svh"

    cpu_core cpu_core_inst (
        .clk          (clk),
        .native_rstn  (native_rstn),
        .usr_rst      (usr_rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // synchronous instruction memory, data one cycle after the address
    always @(posedge clk) begin
        mem_addr_q = imem_addr;
        #1;
        if ($isunknown(mem_addr_q)) begin
            imem_data = '0;
        end else begin
            imem_data = mem[mem_addr_q];
        end
    end

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, logic is_reg,
                                      word_t a, word_t b);
        case (f3)
            3'd0: return (alt && is_reg) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // one instruction of the reference machine
    task automatic ref_step(input word_t pc, output word_t next_pc, output logic we,
                            output reg_addr_t rd, output word_t data, output logic illegal);
        word_t ins;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_b;
        word_t imm_j;

        ins   = mem[pc[imem_addr_w+1:2]];
        a     = ref_regs[ins[19:15]];
        b     = ref_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        rd      = ins[11:7];
        next_pc = pc + 32'd4;
        we      = 1'b1;
        data    = '0;
        illegal = 1'b0;
        case (ins[6:0])
            op_reg: data = alu_ref(ins[14:12], ins[30], 1'b1, a, b);
            op_imm: data = alu_ref(ins[14:12], ins[30], 1'b0, a, imm_i);
            op_lui: data = {ins[31:12], 12'h000};
            op_jal: begin
                data    = pc + 32'd4;
                next_pc = (pc + imm_j) & ~32'd3;
            end
            op_jalr: begin
                data    = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd3;
            end
            op_branch: begin
                we = 1'b0;
                if (branch_ref(ins[14:12], a, b)) begin
                    next_pc = (pc + imm_b) & ~32'd3;
                end
            end
            default: begin
                we      = 1'b0;
                illegal = 1'b1;
            end
        endcase
        if (we && rd != 5'd0) begin
            ref_regs[rd] = data;
        end
    endtask

    task automatic fill_memory();
        for (int a = 0; a < imem_words; a++) begin
            // illegal opcode, upper bits carry the word address
            mem[a] = (word_t'(a) << 7) | 32'h0000_007f;
        end
        build_program();
    endtask

    task automatic build_reference();
        word_t     pc;
        word_t     npc;
        word_t     data;
        logic      we;
        logic      ill;
        reg_addr_t rd;
        int        steps;

        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        pc    = '0;
        ill   = 1'b0;
        steps = 0;
        while (!ill && steps < 4 * prog_len) begin
            ref_step(pc, npc, we, rd, data, ill);
            if (!ill) begin
                exp_pc.push_back(pc);
                exp_we.push_back(we);
                exp_rd.push_back(rd);
                exp_data.push_back(data);
                pc = npc;
            end
            steps++;
        end
    endtask

    task automatic check_retire(input int n);
        assert (retire_pc === exp_pc[n]) else begin
            $display("FAILED retire_pc: got 0x%h, expected 0x%h", retire_pc, exp_pc[n]);
            value_errors++;
        end
        assert (retire_we === exp_we[n]) else begin
            $display("FAILED retire_we at pc 0x%h: got 0x%h, expected 0x%h",
                     exp_pc[n], retire_we, exp_we[n]);
            value_errors++;
        end
        // rd and data only mean something on a write
        if (exp_we[n]) begin
            assert (retire_rd === exp_rd[n]) else begin
                $display("FAILED retire_rd at pc 0x%h: got 0x%h, expected 0x%h",
                         exp_pc[n], retire_rd, exp_rd[n]);
                value_errors++;
            end
            assert (retire_data === exp_data[n]) else begin
                $display("FAILED retire_data at pc 0x%h: got 0x%h, expected 0x%h",
                         exp_pc[n], retire_data, exp_data[n]);
                value_errors++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (retire_valid === 1'b1) begin
            if (halt_seen) begin
                $display("retire at pc 0x%h after the core had halted", retire_pc);
                other_errors++;
            end else if (ret_idx >= exp_pc.size()) begin
                $display("more retires than the reference program produced");
                other_errors++;
            end else begin
                check_retire(ret_idx);
                ret_idx++;
            end
        end
        if (halted === 1'b1) begin
            halt_seen = 1'b1;
        end
    end

    task automatic finish_run(input int run);
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        assert (ret_idx == exp_pc.size()) else begin
            $display("run %0d halted after %0d retires instead of %0d",
                     run, ret_idx, exp_pc.size());
            other_errors++;
        end
        // stay a while to catch retires after halt
        repeat (20) @(negedge clk);
    endtask

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core did not reach halt", cycles);
        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        native_rstn  = 1'b0;
        usr_rst      = 1'b0;
        imem_data    = '0;
        rng_state    = 32'hfcc3;
        value_errors = 0;
        other_errors = 0;
        ret_idx      = 0;
        halt_seen    = 1'b0;
        fill_memory();
        build_reference();

        repeat (9) @(posedge clk);
        @(negedge clk);
        assert (retire_valid === 1'b0 && retire_we === 1'b0 && halted === 1'b0) else begin
            $display("retire_valid, retire_we or halted not low during reset");
            other_errors++;
        end
        @(posedge clk);
        #1 native_rstn = 1'b1;
        finish_run(1);

        // restart from the halted state
        @(posedge clk);
        #1 usr_rst = 1'b1;
        @(posedge clk);
        #1 usr_rst = 1'b0;
        ret_idx   = 0;
        halt_seen = 1'b0;
        @(negedge clk);
        assert (halted === 1'b0) else begin
            $display("halted still high after the usr_rst pulse");
            other_errors++;
        end
        finish_run(2);

        $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
src/rv_pkg.sv
src/core_ifs.sv
src/inst_fetch.sv
src/inst_decode.sv
src/exec_unit.sv
src/reg_file.sv
src/core_control.sv
src/cpu_core.sv
verification/cpu_core_tb.sv
